// ==== prefix_pkg.sv ====
/* Prefix recognizer package
   Sizes, payload structs, the tournament pair rule and the APB register map */
package prefix_pkg;

  // ====================
  // Sizes
  // ====================
  localparam int NUM_NEURONS = 64;
  localparam int IDX_W       = $clog2(NUM_NEURONS);
  localparam int SUM_W       = 16;
  localparam int ACT_W       = 8;
  localparam int SHIFT_W     = 4;
  localparam int MAX_SHIFT   = 8;
  // Survivors handed from stage 2 to stage 3
  localparam int NUM_SURV    = 8;
  localparam int APB_AW      = 4;
  localparam int APB_DW      = 32;

  typedef logic signed [SUM_W-1:0] sum_t;
  typedef logic signed [ACT_W-1:0] act_t;

  localparam act_t ACT_MIN = {1'b1, {(ACT_W-1){1'b0}}};
  localparam act_t ACT_MAX = {1'b0, {(ACT_W-1){1'b1}}};

  // ====================
  // Payloads
  // ====================
  typedef sum_t [NUM_NEURONS-1:0] sum_vec_t;
  typedef act_t [NUM_NEURONS-1:0] act_vec_t;

  typedef struct packed {
    logic [IDX_W-1:0] index;
    act_t             value;
  } neuron_cand_t;

  typedef neuron_cand_t [NUM_SURV-1:0] cand8_t;

  typedef struct packed {
    logic [IDX_W-1:0] prefix;
    act_t             max_value;
    logic             hit;
  } prefix_result_t;

  typedef struct packed {
    logic [SHIFT_W-1:0]     shift;
    act_t                   threshold;
    logic [NUM_NEURONS-1:0] en;
  } rec_cfg_t;

  // Register map
  localparam logic [APB_AW-1:0] REG_CTRL   = 4'h0;
  localparam logic [APB_AW-1:0] REG_THRESH = 4'h4;
  localparam logic [APB_AW-1:0] REG_EN_LO  = 4'h8;
  localparam logic [APB_AW-1:0] REG_EN_HI  = 4'hC;

  // Odd candidate wins only when strictly greater, so ties keep the lower index
  function automatic neuron_cand_t cand_pick(input neuron_cand_t even_c,
                                             input neuron_cand_t odd_c);
    if (odd_c.value > even_c.value) begin
      return odd_c;
    end
    return even_c;
  endfunction

endpackage

// ==== prefix_apb_regs.sv ====
/* APB configuration registers for the prefix recognizer
   Holds quantization shift, threshold and neuron enable mask */
module prefix_apb_regs #(
  parameter prefix_pkg::act_t THRESH_RESET = '0
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [prefix_pkg::APB_AW-1:0]   paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [prefix_pkg::APB_DW-1:0]   pwdata,
  output logic [prefix_pkg::APB_DW-1:0]   prdata,
  output logic                            pready,
  output logic                            pslverr,
  output prefix_pkg::rec_cfg_t            cfg
);

  import prefix_pkg::*;

  logic                   access;
  logic                   wr_en;
  logic                   mapped;
  logic [SHIFT_W-1:0]     shift_q;
  logic [SHIFT_W-1:0]     shift_wr;
  act_t                   thresh_q;
  logic [NUM_NEURONS-1:0] en_q;

  // ====================
  // Decode
  // ====================
  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  always_comb begin
    case (paddr)
      REG_CTRL, REG_THRESH, REG_EN_LO, REG_EN_HI: mapped = 1'b1;
      default:                                    mapped = 1'b0;
    endcase
  end

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access & ~mapped;

  // Clamp keeps the stored shift legal
  always_comb begin
    if (pwdata[SHIFT_W-1:0] > SHIFT_W'(MAX_SHIFT)) begin
      shift_wr = SHIFT_W'(MAX_SHIFT);
    end else begin
      shift_wr = pwdata[SHIFT_W-1:0];
    end
  end

  // ====================
  // Registers
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q  <= '0;
      thresh_q <= THRESH_RESET;
      en_q     <= '1;
    end else if (wr_en) begin
      case (paddr)
        REG_CTRL:   shift_q          <= shift_wr;
        REG_THRESH: thresh_q         <= pwdata[ACT_W-1:0];
        REG_EN_LO:  en_q[31:0]       <= pwdata;
        REG_EN_HI:  en_q[63:32]      <= pwdata;
        default:    ;
      endcase
    end
  end

  // Read mux, unmapped offsets return 0
  always_comb begin
    prdata = '0;
    if (psel) begin
      case (paddr)
        REG_CTRL:   prdata = {{(APB_DW-SHIFT_W){1'b0}}, shift_q};
        REG_THRESH: prdata = {{(APB_DW-ACT_W){1'b0}}, thresh_q};
        REG_EN_LO:  prdata = en_q[31:0];
        REG_EN_HI:  prdata = en_q[63:32];
        default:    prdata = '0;
      endcase
    end
  end

  assign cfg.shift     = shift_q;
  assign cfg.threshold = thresh_q;
  assign cfg.en        = en_q;

endmodule

// ==== prefix_quantize.sv ====
/* Stage 1, quantizes 64 neuron sums to saturated 8-bit activations */
module prefix_quantize (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hold,
  input  logic                 in_valid,
  input  prefix_pkg::sum_vec_t in_sums,
  input  prefix_pkg::rec_cfg_t cfg,
  output logic                 act_valid,
  output prefix_pkg::act_vec_t act
);

  import prefix_pkg::*;

  sum_t     shifted [NUM_NEURONS];
  act_vec_t act_d;

  // Clip a shifted sum into the activation range
  function automatic act_t saturate(input sum_t value);
    if (value > ACT_MAX) begin
      return ACT_MAX;
    end
    if (value < ACT_MIN) begin
      return ACT_MIN;
    end
    return value[ACT_W-1:0];
  endfunction

  // ====================
  // Shift and saturate
  // ====================
  always_comb begin
    for (int i = 0; i < NUM_NEURONS; i++) begin
      // Arithmetic shift keeps the sign
      shifted[i] = in_sums[i] >>> cfg.shift;
      act_d[i]   = saturate(shifted[i]);
    end
  end

  // ====================
  // Stage register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      act_valid <= 1'b0;
    end else if (!hold) begin
      act_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      act <= act_d;
    end
  end

endmodule

// ==== prefix_argmax.sv ====
/* Stage 2, masks disabled neurons and runs the first three tournament levels
   The 8 surviving candidates are registered for the decide stage */
module prefix_argmax (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hold,
  input  logic                 act_valid,
  input  prefix_pkg::act_vec_t act,
  input  prefix_pkg::rec_cfg_t cfg,
  output logic                 cand_valid,
  output prefix_pkg::cand8_t   cand
);

  import prefix_pkg::*;

  localparam int L1_N = NUM_NEURONS / 2;
  localparam int L2_N = NUM_NEURONS / 4;

  neuron_cand_t lvl0 [NUM_NEURONS];
  neuron_cand_t lvl1 [L1_N];
  neuron_cand_t lvl2 [L2_N];
  cand8_t       cand_d;

  // ====================
  // Candidates
  // ====================
  always_comb begin
    for (int i = 0; i < NUM_NEURONS; i++) begin
      lvl0[i].index = IDX_W'(i);
      // Disabled neurons can never beat an enabled one
      if (cfg.en[i]) begin
        lvl0[i].value = act[i];
      end else begin
        lvl0[i].value = ACT_MIN;
      end
    end
  end

  // ====================
  // Tournament 64 to 8
  // ====================
  always_comb begin
    for (int i = 0; i < L1_N; i++) begin
      lvl1[i] = cand_pick(lvl0[2*i], lvl0[2*i+1]);
    end
  end

  always_comb begin
    for (int i = 0; i < L2_N; i++) begin
      lvl2[i] = cand_pick(lvl1[2*i], lvl1[2*i+1]);
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_SURV; i++) begin
      cand_d[i] = cand_pick(lvl2[2*i], lvl2[2*i+1]);
    end
  end

  // ====================
  // Stage register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cand_valid <= 1'b0;
    end else if (!hold) begin
      cand_valid <= act_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      cand <= cand_d;
    end
  end

endmodule

// ==== prefix_decide.sv ====
/* Stage 3, finds the single winner and applies the threshold */
module prefix_decide (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       hold,
  input  logic                       cand_valid,
  input  prefix_pkg::cand8_t         cand,
  input  prefix_pkg::rec_cfg_t       cfg,
  output logic                       out_valid,
  output prefix_pkg::prefix_result_t out_result
);

  import prefix_pkg::*;

  neuron_cand_t   lvl4 [NUM_SURV/2];
  neuron_cand_t   lvl2 [NUM_SURV/4];
  neuron_cand_t   winner;
  prefix_result_t result_d;

  // ====================
  // Tournament 8 to 1
  // ====================
  always_comb begin
    for (int i = 0; i < NUM_SURV / 2; i++) begin
      lvl4[i] = cand_pick(cand[2*i], cand[2*i+1]);
    end
    for (int i = 0; i < NUM_SURV / 4; i++) begin
      lvl2[i] = cand_pick(lvl4[2*i], lvl4[2*i+1]);
    end
    winner = cand_pick(lvl2[0], lvl2[1]);
  end

  // Prefix only reported on a hit
  always_comb begin
    result_d.hit       = (winner.value >= cfg.threshold);
    result_d.max_value = winner.value;
    result_d.prefix    = result_d.hit ? winner.index : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= cand_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      out_result <= result_d;
    end
  end

endmodule

// ==== prefix_rec_top.sv ====
/* Prefix recognizer output stage
   APB configuration plus a three stage quantize, argmax and decide pipeline */
module prefix_rec_top #(
  parameter prefix_pkg::act_t THRESH_RESET = '0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // APB slave
  input  logic [prefix_pkg::APB_AW-1:0]  paddr,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [prefix_pkg::APB_DW-1:0]  pwdata,
  output logic [prefix_pkg::APB_DW-1:0]  prdata,
  output logic                           pready,
  output logic                           pslverr,
  // Data path
  input  logic                           hold,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  prefix_pkg::sum_vec_t           in_sums,
  output logic                           out_valid,
  output prefix_pkg::prefix_result_t     out_result
);

  import prefix_pkg::*;

  rec_cfg_t cfg;
  logic     act_valid;
  act_vec_t act;
  logic     cand_valid;
  cand8_t   cand;

  // Whole pipeline stalls together
  assign in_ready = ~hold;

  prefix_apb_regs #(
    .THRESH_RESET (THRESH_RESET)
  ) i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg)
  );

  prefix_quantize i_quantize (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .in_valid  (in_valid),
    .in_sums   (in_sums),
    .cfg       (cfg),
    .act_valid (act_valid),
    .act       (act)
  );

  prefix_argmax i_argmax (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .act_valid  (act_valid),
    .act        (act),
    .cfg        (cfg),
    .cand_valid (cand_valid),
    .cand       (cand)
  );

  prefix_decide i_decide (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .cand_valid (cand_valid),
    .cand       (cand),
    .cfg        (cfg),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

endmodule

// ==== tb_prefix_model.svh ====
/* Testbench model for the prefix recognizer
   LFSR stimulus source, expected result function and value check */
`ifndef TB_PREFIX_MODEL_SVH
`define TB_PREFIX_MODEL_SVH

logic [31:0] lfsr_state = 32'h49d4_1806;

// Galois LFSR, one step per returned bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return r;
endfunction

// Expected output for one item: quantize, mask, first maximum, threshold
function automatic prefix_result_t ref_result(input sum_vec_t sums, input logic [3:0] shift,
                                              input act_t thresh, input logic [63:0] en);
  prefix_result_t r;
  int v;
  int best_v;
  int best_i;
  best_v = -129;
  best_i = 0;
  for (int i = 0; i < NUM_NEURONS; i++) begin
    v = int'(sums[i]) >>> shift;
    if (v > 127) begin
      v = 127;
    end else if (v < -128) begin
      v = -128;
    end
    if (!en[i]) begin
      v = -128;
    end
    // Strictly greater keeps the lowest index among equal maxima
    if (v > best_v) begin
      best_v = v;
      best_i = i;
    end
  end
  r.max_value = act_t'(best_v);
  r.hit       = (best_v >= int'(thresh));
  r.prefix    = r.hit ? 6'(best_i) : 6'd0;
  return r;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    stop_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

`endif

// ==== tb_prefix_rec.sv ====
/* Testbench for the prefix recognizer
   APB register checks and random item traffic against a reference model */
module tb_prefix_rec;

  import prefix_pkg::*;

  localparam act_t THRESH_RST = 8'h10;
  localparam int   N_ITEMS    = 460;
  localparam int   N_APB      = 67;

  logic              clk = 1'b0;
  logic              rst_n;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic              hold;
  logic              in_valid;
  logic              in_ready;
  sum_vec_t          in_sums;
  logic              out_valid;
  prefix_result_t    out_result;

  logic [3:0]        cfg_shift;
  act_t              cfg_thresh;
  logic [63:0]       cfg_en;
  prefix_result_t    exp_q [$];
  int                acc_q [$];
  int                cycle_cnt = 0;
  logic [31:0]       rdata;
  logic              rerr;

  `include "tb_prefix_model.svh"

  prefix_rec_top #(.THRESH_RESET(THRESH_RST)) i_dut (.*);

  always #50 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // ====================
  // APB driver
  // ====================
  task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [31:0] wdata);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    rdata = prdata;
    rerr  = pslverr;
    check_value("pready", pready, 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    apb_access(addr, 1'b0, 32'h0);
    check_value("prdata", rdata, exp_data);
    check_value("pslverr", rerr, exp_err);
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    apb_access(addr, 1'b1, data);
    check_value("pslverr", rerr, exp_err);
  endtask

  task automatic set_config(input logic [3:0] shift, input act_t thresh, input logic [63:0] en);
    // Pipeline must be empty before the stages see new settings
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    reg_write(REG_CTRL, shift, 1'b0);
    reg_write(REG_THRESH, {24'h0, thresh}, 1'b0);
    reg_write(REG_EN_LO, en[31:0], 1'b0);
    reg_write(REG_EN_HI, en[63:32], 1'b0);
    cfg_shift  = shift;
    cfg_thresh = thresh;
    cfg_en     = en;
  endtask

  // ====================
  // Item stimulus
  // ====================
  // Mode 0 full range, 1 small, 2 small with three ties at 100, 3 extremes only,
  // 4 negative only
  function automatic sum_vec_t gen_sums(input int mode);
    sum_vec_t    s;
    logic [31:0] r;
    for (int i = 0; i < NUM_NEURONS; i++) begin
      case (mode)
        1: begin
          r    = rand_bits(9);
          s[i] = {{7{r[8]}}, r[8:0]};
        end
        2: begin
          r    = rand_bits(6);
          s[i] = {{10{r[5]}}, r[5:0]};
        end
        3: s[i] = rand_bits(1) ? 16'h7fff : 16'h8000;
        4: begin
          r    = rand_bits(15);
          s[i] = {1'b1, r[14:0]};
        end
        default: s[i] = rand_bits(16);
      endcase
    end
    if (mode == 2) begin
      for (int k = 0; k < 3; k++) begin
        r    = rand_bits(6);
        s[r[5:0]] = 16'sd100;
      end
    end
    return s;
  endfunction

  task automatic send_items(input int n, input int mode, input logic stall);
    logic [31:0] r;
    int          sent;
    sent = 0;
    while (sent < n) begin
      @(negedge clk);
      r        = rand_bits(4);
      hold     = stall && (r[1:0] == 2'b00);
      in_valid = (r[3:2] != 2'b00);
      in_sums  = gen_sums(mode);
      if (in_valid && !hold) begin
        exp_q.push_back(ref_result(in_sums, cfg_shift, cfg_thresh, cfg_en));
        acc_q.push_back(stall ? -1 : cycle_cnt + 1);
        sent++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    hold     = 1'b0;
  endtask

  // ====================
  // Output compare
  // ====================
  always @(posedge clk) begin : compare_out
    prefix_result_t exp_r;
    int             acc;
    cycle_cnt = cycle_cnt + 1;
    check_value("in_ready", in_ready, !hold);
    if (out_valid && !hold) begin
      if (exp_q.size() == 0) begin
        stop_run("Output valid while no result was expected");
      end else begin
        exp_r = exp_q.pop_front();
        acc   = acc_q.pop_front();
        check_value("prefix", out_result.prefix, exp_r.prefix);
        check_value("max_value", out_result.max_value, exp_r.max_value);
        check_value("hit", out_result.hit, exp_r.hit);
        if (acc >= 0 && cycle_cnt - acc != 3) begin
          stop_run($sformatf("Result came %0d edges after its item, not 3", cycle_cnt - acc));
        end
      end
    end
  end

  initial begin
    #((20 * N_ITEMS + N_APB) * 100);
    stop_run("Timeout, the test did not finish in time");
  end

  initial begin
    rst_n      = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    hold       = 1'b0;
    in_valid   = 1'b0;
    in_sums    = '0;
    cfg_shift  = '0;
    cfg_thresh = THRESH_RST;
    cfg_en     = '1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Reset values, write and read back, shift clamp, unmapped offsets
    reg_read(REG_CTRL, 32'h0, 1'b0);
    reg_read(REG_THRESH, {24'h0, THRESH_RST}, 1'b0);
    reg_read(REG_EN_LO, 32'hffff_ffff, 1'b0);
    reg_read(REG_EN_HI, 32'hffff_ffff, 1'b0);
    reg_write(REG_CTRL, 32'h3, 1'b0);
    reg_write(REG_THRESH, 32'h85, 1'b0);
    reg_write(REG_EN_LO, 32'ha5a5_1234, 1'b0);
    reg_write(REG_EN_HI, 32'h0f0f_f0f0, 1'b0);
    reg_read(REG_CTRL, 32'h3, 1'b0);
    reg_read(REG_THRESH, 32'h85, 1'b0);
    reg_read(REG_EN_LO, 32'ha5a5_1234, 1'b0);
    reg_read(REG_EN_HI, 32'h0f0f_f0f0, 1'b0);
    reg_write(REG_CTRL, 32'hf, 1'b0);
    reg_read(REG_CTRL, 32'h8, 1'b0);
    reg_write(REG_CTRL, 32'h9, 1'b0);
    reg_read(REG_CTRL, 32'h8, 1'b0);
    reg_read(4'h2, 32'h0, 1'b1);
    reg_write(4'h6, 32'hffff_ffff, 1'b1);
    reg_read(REG_THRESH, 32'h85, 1'b0);

    // Quantization at three shifts, saturation from full range, extreme and negative sums
    for (int s = 0; s <= 8; s += 4) begin
      set_config(4'(s), ACT_MIN, '1);
      send_items(30, 0, 1'b1);
      send_items(10, 3, 1'b1);
      send_items(10, 4, 1'b1);
    end

    // Masking and ties
    set_config(4'd0, ACT_MIN, {rand_bits(32), rand_bits(32)});
    send_items(40, 2, 1'b1);
    set_config(4'd0, ACT_MIN, '0);
    send_items(10, 0, 1'b1);

    // Threshold at the top, random, equal to the winner and just above it
    set_config(4'd0, ACT_MAX, '1);
    send_items(20, 0, 1'b1);
    repeat (3) begin
      set_config(4'd1, act_t'(rand_bits(8)), '1);
      send_items(20, 1, 1'b1);
    end
    set_config(4'd0, 8'sd100, '1);
    send_items(20, 2, 1'b1);
    set_config(4'd0, 8'sd101, '1);
    send_items(20, 2, 1'b1);

    // Throughput with stalls, then fixed latency with hold low
    set_config(4'd2, act_t'(rand_bits(8)), {rand_bits(32), rand_bits(32)});
    send_items(100, 0, 1'b1);
    send_items(40, 1, 1'b0);

    repeat (20) @(posedge clk);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d expected results never came out", exp_q.size()));
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+.
prefix_pkg.sv
prefix_apb_regs.sv
prefix_quantize.sv
prefix_argmax.sv
prefix_decide.sv
prefix_rec_top.sv
tb_prefix_rec.sv
